// File: bedrock_stream_pkg.sv
// shared definitions for the burst stream memory endpoint
// widths of the address, beat and block, the message types,
// the command and response header and the per-type stream masks

package bedrock_stream_pkg;

  // physical address and data widths
  localparam int paddr_width_c       = 12;
  localparam int stream_data_width_c = 64;
  localparam int block_width_c       = 256;

  // one beat per 64-bit word, four words to a block
  localparam int stream_words_c        = block_width_c / stream_data_width_c;
  localparam int stream_cnt_width_c    = $clog2(stream_words_c);
  // byte offset bits inside one word
  localparam int stream_offset_width_c = $clog2(stream_data_width_c / 8);

  // backing store, four blocks of four words
  localparam int mem_words_c     = 16;
  localparam int mem_idx_width_c = $clog2(mem_words_c);

  // message types, the value doubles as the bit index into the stream masks
  typedef enum logic [1:0] {
    e_rd    = 2'd0,
    e_wr    = 2'd1,
    e_uc_rd = 2'd2,
    e_uc_wr = 2'd3
  } msg_type_e;

  // size is log2 of the byte count, 0 is 1 byte, 5 is a full 32-byte block
  typedef struct packed {
    msg_type_e                msg_type;
    logic [paddr_width_c-1:0] addr;
    logic [2:0]               size;
  } bedrock_header_s;

  // types that go out as several beats on the response side
  localparam logic [3:0] msg_stream_mask_c = (4'b1 << e_rd) | (4'b1 << e_wr);
  // types where the FSM itself supplies one beat per word
  localparam logic [3:0] fsm_stream_mask_c = (4'b1 << e_rd);

  // output pump, idle or partway through a multi-beat message
  typedef enum logic {
    e_ready,
    e_stream
  } resp_state_e;

  // memory FSM, waiting for a command or answering one
  typedef enum logic {
    e_idle,
    e_busy
  } mem_state_e;

endpackage

// File: stream_wraparound.sv
// loadable word counter for stream beats
// full_o is the running count, wrap_o keeps the loaded base's high bits
// and takes its low bits from the count, so the index wraps inside an
// aligned group of max_i + 1 words

module stream_wraparound
  import bedrock_stream_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic [stream_cnt_width_c-1:0] max_i,
  input  logic                          set_i,
  input  logic [stream_cnt_width_c-1:0] val_i,
  input  logic                          en_i,
  output logic [stream_cnt_width_c-1:0] full_o,
  output logic [stream_cnt_width_c-1:0] wrap_o
);

  logic [stream_cnt_width_c-1:0] cnt_r;
  logic [stream_cnt_width_c-1:0] base_r;
  logic [stream_cnt_width_c-1:0] low_mask;

  // set and enable on the same edge load the value already advanced by one,
  // the first beat is usually sent in the cycle that loads the counter
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cnt_r  <= '0;
      base_r <= '0;
    end
    else if (set_i)
    begin
      cnt_r  <= val_i + stream_cnt_width_c'(en_i);
      base_r <= val_i;
    end
    else if (en_i)
    begin
      cnt_r <= cnt_r + stream_cnt_width_c'(1);
    end
  end

  // ones at and below the top set bit of max_i, ceil of log2(max_i + 1)
  always_comb
  begin
    for (int i = 0; i < stream_cnt_width_c; i++)
    begin
      low_mask[i] = |(max_i >> i);
    end
  end

  assign full_o = cnt_r;
  assign wrap_o = (base_r & ~low_mask) | (cnt_r & low_mask);

endmodule

// File: stream_pump_out.sv
// stream output pump
// takes a base header held by the FSM plus its data beats and sends a
// response stream, one beat per word, with wrapped addresses and a last flag
// 1:1 when the FSM streams the type too, 1:N when one FSM beat fans out

module stream_pump_out
  import bedrock_stream_pkg::*;
#(
  parameter logic [3:0] msg_stream_mask_p = msg_stream_mask_c,
  parameter logic [3:0] fsm_stream_mask_p = fsm_stream_mask_c
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // FSM side, header held from the first beat through fsm_done_o
  input  bedrock_header_s                fsm_base_header_i,
  input  logic [stream_data_width_c-1:0] fsm_data_i,
  input  logic                           fsm_v_i,
  output logic                           fsm_ready_and_o,
  output logic [stream_cnt_width_c-1:0]  fsm_cnt_o,
  output logic                           fsm_new_o,
  output logic                           fsm_last_o,
  output logic                           fsm_done_o,
  // response stream
  output bedrock_header_s                resp_header_o,
  output logic [stream_data_width_c-1:0] resp_data_o,
  output logic                           resp_v_o,
  output logic                           resp_last_o,
  input  logic                           resp_ready_and_i
);

  resp_state_e state_r;
  resp_state_e state_n;
  logic        is_ready;
  logic        is_stream;

  logic [7:0]                    size_bytes;
  logic [7:0]                    size_words;
  logic [stream_cnt_width_c-1:0] stream_size;
  logic                          nz_stream;
  logic                          fsm_stream;
  logic                          msg_stream;
  logic                          any_stream;
  logic                          conv_1n;

  logic [stream_cnt_width_c-1:0] stream_cnt;
  logic [stream_cnt_width_c-1:0] wrap_cnt;
  logic [stream_cnt_width_c-1:0] cnt_max;
  logic [stream_cnt_width_c-1:0] first_cnt;
  logic [stream_cnt_width_c-1:0] last_cnt;
  logic                          cnt_up;
  logic                          is_last_cnt;
  logic                          beat_sent;
  logic [paddr_width_c-1:0]      wrap_addr;

  assign is_ready  = (state_r == e_ready);
  assign is_stream = (state_r == e_stream);

  // words in the message minus one, never below zero for sub-word sizes
  assign size_bytes  = 8'd1 << fsm_base_header_i.size;
  assign size_words  = size_bytes >> stream_offset_width_c;
  assign stream_size = (size_words == '0) ? '0 : stream_cnt_width_c'(size_words - 8'd1);
  assign nz_stream   = (stream_size != '0);

  // which side streams for this type
  assign fsm_stream = fsm_stream_mask_p[fsm_base_header_i.msg_type] & nz_stream;
  assign msg_stream = msg_stream_mask_p[fsm_base_header_i.msg_type] & nz_stream;
  assign any_stream = fsm_stream | msg_stream;
  assign conv_1n    = msg_stream & ~fsm_stream;

  // critical word of the request, the stream starts here
  assign first_cnt = fsm_base_header_i.addr[stream_offset_width_c +: stream_cnt_width_c];
  assign last_cnt  = first_cnt + stream_size;
  assign cnt_max   = any_stream ? stream_size : '0;

  stream_wraparound u_cnt (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .max_i  (cnt_max),
    .set_i  (fsm_new_o),
    .val_i  (first_cnt),
    .en_i   (cnt_up),
    .full_o (stream_cnt),
    .wrap_o (wrap_cnt)
  );

  // single beat messages are always on their last word
  assign is_last_cnt = (is_stream & (stream_cnt == last_cnt)) | ~any_stream;

  // every FSM beat offers a response beat in both conversions
  assign resp_v_o  = fsm_v_i;
  assign beat_sent = resp_v_o & resp_ready_and_i;
  assign cnt_up    = beat_sent & ~is_last_cnt;

  // 1:N holds the single FSM beat until the final response beat leaves
  assign fsm_ready_and_o = conv_1n ? (is_last_cnt & resp_ready_and_i) : resp_ready_and_i;

  // new marks the first response beat, not the FSM ack, so 1:N can start
  assign fsm_new_o  = beat_sent & is_ready;
  assign fsm_last_o = fsm_v_i & is_last_cnt;
  assign fsm_done_o = fsm_ready_and_o & fsm_v_i & is_last_cnt;
  assign fsm_cnt_o  = is_stream ? wrap_cnt : first_cnt;

  // high bits and byte offset kept, word index replaced by the wrapped count
  assign wrap_addr = {
    fsm_base_header_i.addr[paddr_width_c-1:stream_offset_width_c+stream_cnt_width_c],
    wrap_cnt,
    fsm_base_header_i.addr[stream_offset_width_c-1:0]
  };

  always_comb
  begin
    resp_header_o      = fsm_base_header_i;
    // first beat goes out at the critical address, which is the wrap start
    resp_header_o.addr = is_stream ? wrap_addr : fsm_base_header_i.addr;
    resp_data_o        = fsm_data_i;
    resp_last_o        = is_last_cnt & resp_v_o;
  end

  always_comb
  begin
    case (state_r)
      e_stream: state_n = fsm_done_o ? e_ready : e_stream;
      default:  state_n = (fsm_new_o & any_stream) ? e_stream : e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_ready;
    else
      state_r <= state_n;
  end

endmodule

// File: mem_resp_fsm.sv
// memory response FSM
// accepts one command at a time, writes or reads a 16-word store and
// hands the pump a held base header plus the data word for each beat

module mem_resp_fsm
  import bedrock_stream_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,
  // command in
  input  bedrock_header_s                cmd_header_i,
  input  logic [stream_data_width_c-1:0] cmd_data_i,
  input  logic                           cmd_v_i,
  output logic                           cmd_ready_and_o,
  // toward the output pump
  output bedrock_header_s                fsm_base_header_o,
  output logic [stream_data_width_c-1:0] fsm_data_o,
  output logic                           fsm_v_o,
  input  logic                           fsm_ready_and_i,
  input  logic [stream_cnt_width_c-1:0]  fsm_cnt_i,
  input  logic                           fsm_done_i
);

  mem_state_e state_r;

  bedrock_header_s                hdr_r;
  logic [stream_data_width_c-1:0] data_r;
  logic [stream_data_width_c-1:0] mem_r [mem_words_c];

  logic                       cmd_fire;
  logic                       cmd_is_wr;
  logic                       hdr_is_rd;
  logic                       resp_done;
  logic [mem_idx_width_c-1:0] wr_idx;
  logic [mem_idx_width_c-1:0] rd_idx;

  assign cmd_ready_and_o = (state_r == e_idle);
  assign cmd_fire        = cmd_v_i & cmd_ready_and_o;
  assign cmd_is_wr       = (cmd_header_i.msg_type == e_wr) | (cmd_header_i.msg_type == e_uc_wr);
  assign hdr_is_rd       = (hdr_r.msg_type == e_rd) | (hdr_r.msg_type == e_uc_rd);

  // final beat handed over to the pump
  assign resp_done = fsm_v_o & fsm_ready_and_i & fsm_done_i;

  // word address straight from the command, upper address bits alias
  assign wr_idx = cmd_header_i.addr[stream_offset_width_c +: mem_idx_width_c];
  // block of the held command, word from the pump's wrapped count
  assign rd_idx = {
    hdr_r.addr[stream_offset_width_c+mem_idx_width_c-1:stream_offset_width_c+stream_cnt_width_c],
    fsm_cnt_i
  };

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
    end
    else
    begin
      case (state_r)
        e_idle:
        begin
          if (cmd_fire)
            state_r <= e_busy;
        end
        default:
        begin
          if (resp_done)
            state_r <= e_idle;
        end
      endcase
    end
  end

  // command held for the whole response
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      hdr_r  <= cmd_header_i;
      data_r <= cmd_data_i;
    end
  end

  // store starts out zeroed, one word written per write command
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < mem_words_c; i++)
        mem_r[i] <= '0;
    end
    else if (cmd_fire && cmd_is_wr)
    begin
      mem_r[wr_idx] <= cmd_data_i;
    end
  end

  assign fsm_base_header_o = hdr_r;
  assign fsm_v_o           = (state_r == e_busy);
  // reads follow the pump's count, write acks echo the written word
  assign fsm_data_o        = hdr_is_rd ? mem_r[rd_idx] : data_r;

endmodule

// File: stream_mem_top.sv
// stream memory endpoint top
// joins the memory response FSM to the output pump and exposes the
// single-beat command port and the response stream port

module stream_mem_top
  import bedrock_stream_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,
  // command
  input  bedrock_header_s                cmd_header_i,
  input  logic [stream_data_width_c-1:0] cmd_data_i,
  input  logic                           cmd_v_i,
  output logic                           cmd_ready_and_o,
  // response stream
  output bedrock_header_s                resp_header_o,
  output logic [stream_data_width_c-1:0] resp_data_o,
  output logic                           resp_v_o,
  output logic                           resp_last_o,
  input  logic                           resp_ready_and_i
);

  bedrock_header_s                fsm_base_header;
  logic [stream_data_width_c-1:0] fsm_data;
  logic                           fsm_v;
  logic                           fsm_ready_and;
  logic [stream_cnt_width_c-1:0]  fsm_cnt;
  logic                           fsm_done;

  mem_resp_fsm u_fsm (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cmd_header_i     (cmd_header_i),
    .cmd_data_i       (cmd_data_i),
    .cmd_v_i          (cmd_v_i),
    .cmd_ready_and_o  (cmd_ready_and_o),
    .fsm_base_header_o(fsm_base_header),
    .fsm_data_o       (fsm_data),
    .fsm_v_o          (fsm_v),
    .fsm_ready_and_i  (fsm_ready_and),
    .fsm_cnt_i        (fsm_cnt),
    .fsm_done_i       (fsm_done)
  );

  // new and last are not needed by this FSM
  stream_pump_out #(
    .msg_stream_mask_p(msg_stream_mask_c),
    .fsm_stream_mask_p(fsm_stream_mask_c)
  ) u_pump (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fsm_base_header_i(fsm_base_header),
    .fsm_data_i       (fsm_data),
    .fsm_v_i          (fsm_v),
    .fsm_ready_and_o  (fsm_ready_and),
    .fsm_cnt_o        (fsm_cnt),
    .fsm_new_o        (),
    .fsm_last_o       (),
    .fsm_done_o       (fsm_done),
    .resp_header_o    (resp_header_o),
    .resp_data_o      (resp_data_o),
    .resp_v_o         (resp_v_o),
    .resp_last_o      (resp_last_o),
    .resp_ready_and_i (resp_ready_and_i)
  );

endmodule

// File: tb_resp_checker.sv
// response checker for the stream memory endpoint
// follows accepted commands, keeps a shadow of the 16-word store and
// compares every offered response beat with the beat it should be

module tb_resp_checker
  import bedrock_stream_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  bedrock_header_s                cmd_header_i,
  input  logic [stream_data_width_c-1:0] cmd_data_i,
  input  logic                           cmd_v_i,
  input  logic                           cmd_ready_and_i,
  input  int                             exp_beats_i,
  input  bedrock_header_s                resp_header_i,
  input  logic [stream_data_width_c-1:0] resp_data_i,
  input  logic                           resp_v_i,
  input  logic                           resp_last_i,
  input  logic                           resp_ready_and_i,
  output int                             pass_cnt_o,
  output int                             fail_cnt_o
);

  logic [stream_data_width_c-1:0] shadow [mem_words_c];
  bedrock_header_s                cur_hdr;
  logic [stream_data_width_c-1:0] cur_data;
  int                             cmd_idx;
  int                             beat_idx;
  int                             beat_total;
  bit                             busy;
  bit                             cmd_err;
  bit                             was_reset;
  bit                             last_seen;

  // only the first problem of a command is printed, as its one line
  task automatic flag_cmd(input string msg);
    if (!cmd_err)
      $display("%s", msg);
    cmd_err = 1'b1;
  endtask

  task automatic flag_port(input string msg);
    $display("%s", msg);
    fail_cnt_o++;
  endtask

  task automatic finish_cmd();
    if (cmd_err)
      fail_cnt_o++;
    else
    begin
      pass_cnt_o++;
      $display("cmd %0d type %0d addr %h size %0d: %0d beats ok", cmd_idx,
               cur_hdr.msg_type, cur_hdr.addr, cur_hdr.size, beat_total);
    end
    busy      = 1'b0;
    last_seen = 1'b1;
    cmd_idx++;
  endtask

  // compare the beat on the port with beat beat_idx of the current command
  task automatic check_beat();
    bedrock_header_s                exp_hdr;
    logic [stream_data_width_c-1:0] exp_data;
    logic [stream_cnt_width_c-1:0]  word;
    logic                           exp_last;
    logic                           is_rd;
    // starts at the critical word and wraps modulo 4
    word    = cur_hdr.addr[stream_offset_width_c +: stream_cnt_width_c]
              + stream_cnt_width_c'(beat_idx);
    exp_hdr = cur_hdr;
    // high bits and byte offset stay, the word index follows the wrap
    if (beat_total > 1)
      exp_hdr.addr[stream_offset_width_c +: stream_cnt_width_c] = word;
    is_rd    = (cur_hdr.msg_type == e_rd) || (cur_hdr.msg_type == e_uc_rd);
    exp_data = is_rd ? shadow[{cur_hdr.addr[stream_offset_width_c+stream_cnt_width_c +:
                                            mem_idx_width_c-stream_cnt_width_c], word}]
                     : cur_data;
    exp_last = (beat_idx == beat_total - 1);
    if (!resp_v_i)
      flag_cmd($sformatf("cmd %0d: beat %0d is missing, response valid low at time %0t",
                         cmd_idx, beat_idx, $time));
    else
    begin
      // checked every valid cycle, so a stalled beat must hold its values
      if (resp_header_i !== exp_hdr)
        flag_cmd($sformatf("FAILED at %0t: cmd %0d beat %0d header %h, expected %h",
                           $time, cmd_idx, beat_idx, resp_header_i, exp_hdr));
      if (resp_data_i !== exp_data)
        flag_cmd($sformatf("FAILED at %0t: cmd %0d beat %0d data %h, expected %h",
                           $time, cmd_idx, beat_idx, resp_data_i, exp_data));
      if (resp_last_i !== exp_last)
        flag_cmd($sformatf("FAILED at %0t: cmd %0d beat %0d last %b, expected %b",
                           $time, cmd_idx, beat_idx, resp_last_i, exp_last));
      if (resp_ready_and_i)
      begin
        beat_idx++;
        if (beat_idx == beat_total)
          finish_cmd();
      end
    end
  endtask

  task automatic accept_cmd();
    if (busy)
      flag_port($sformatf("command accepted at time %0t while cmd %0d still owes beats",
                          $time, cmd_idx));
    cur_hdr    = cmd_header_i;
    cur_data   = cmd_data_i;
    beat_total = exp_beats_i;
    beat_idx   = 0;
    cmd_err    = 1'b0;
    busy       = 1'b1;
    // the store takes the written word when the command is accepted
    if ((cmd_header_i.msg_type == e_wr) || (cmd_header_i.msg_type == e_uc_wr))
      shadow[cmd_header_i.addr[stream_offset_width_c +: mem_idx_width_c]] = cmd_data_i;
  endtask

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < mem_words_c; i++)
        shadow[i] = '0;
      busy       = 1'b0;
      cmd_idx    = 0;
      pass_cnt_o = 0;
      fail_cnt_o = 0;
      was_reset  = 1'b1;
      last_seen  = 1'b0;
    end
    else
    begin
      if (was_reset && (!cmd_ready_and_i || resp_v_i))
        flag_port("after reset the command port is not ready or a response is valid");
      if (last_seen && !cmd_ready_and_i)
        flag_port($sformatf("command port not ready at time %0t after a last beat", $time));
      // the FSM takes no new command until the open response has ended
      if (busy && cmd_ready_and_i)
        flag_port($sformatf("command port ready at time %0t while a response is open", $time));
      was_reset = 1'b0;
      last_seen = 1'b0;
      if (busy)
        check_beat();
      else if (resp_v_i)
        flag_port($sformatf("extra response beat at time %0t with no command open", $time));
      if (cmd_v_i && cmd_ready_and_i)
        accept_cmd();
    end
  end

endmodule

// File: tb_stream_mem.sv
// testbench for the stream memory endpoint
// drives a table of commands with optional random back-pressure on the
// response side, the checker beside the DUT compares every response beat

module tb_stream_mem
  import bedrock_stream_pkg::*;
();

  localparam int num_cmds_c       = 14;
  localparam int cycles_per_cmd_c = 40;
  localparam int timeout_c        = num_cmds_c * cycles_per_cmd_c;

  // command, data choice, back-pressure and the beats it should return
  typedef struct packed {
    msg_type_e                msg_type;
    logic [paddr_width_c-1:0] addr;
    logic [2:0]               size;
    logic                     use_lcg;
    logic                     stall;
    logic [2:0]               beats;
  } cmd_entry_s;

  cmd_entry_s                     cmd_table [num_cmds_c];
  logic [stream_data_width_c-1:0] cmd_words [num_cmds_c];

  logic                           clk;
  logic                           reset;
  bedrock_header_s                cmd_header;
  logic [stream_data_width_c-1:0] cmd_data;
  logic                           cmd_v;
  logic                           cmd_ready_and;
  bedrock_header_s                resp_header;
  logic [stream_data_width_c-1:0] resp_data;
  logic                           resp_v;
  logic                           resp_last;
  logic                           resp_ready_and;
  logic [31:0]                    lcg_state;
  logic                           stall_en;
  int                             exp_beats;
  int                             pass_cnt;
  int                             fail_cnt;
  int                             cycle_cnt;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic load_table();
    // writes first so the reads find data
    cmd_table[0]  = '{e_uc_wr, 12'h008, 3'd3, 1'b1, 1'b0, 3'd1};
    cmd_table[1]  = '{e_wr,    12'h010, 3'd5, 1'b1, 1'b0, 3'd4};
    cmd_table[2]  = '{e_wr,    12'h018, 3'd5, 1'b1, 1'b1, 3'd4};
    cmd_table[3]  = '{e_uc_wr, 12'h000, 3'd3, 1'b1, 1'b1, 3'd1};
    // full block reads at each critical word
    cmd_table[4]  = '{e_rd,    12'h000, 3'd5, 1'b0, 1'b0, 3'd4};
    cmd_table[5]  = '{e_rd,    12'h008, 3'd5, 1'b0, 1'b1, 3'd4};
    cmd_table[6]  = '{e_rd,    12'h014, 3'd5, 1'b0, 1'b1, 3'd4};
    cmd_table[7]  = '{e_rd,    12'h018, 3'd5, 1'b0, 1'b0, 3'd4};
    cmd_table[8]  = '{e_wr,    12'h030, 3'd5, 1'b1, 1'b1, 3'd4};
    // zero overwrite, then single beat reads and writes
    cmd_table[9]  = '{e_uc_wr, 12'h008, 3'd3, 1'b0, 1'b0, 3'd1};
    cmd_table[10] = '{e_uc_rd, 12'h008, 3'd3, 1'b0, 1'b1, 3'd1};
    cmd_table[11] = '{e_rd,    12'h43c, 3'd2, 1'b0, 1'b0, 3'd1};
    cmd_table[12] = '{e_wr,    12'h038, 3'd0, 1'b1, 1'b1, 3'd1};
    cmd_table[13] = '{e_rd,    12'h02c, 3'd5, 1'b0, 1'b1, 3'd4};
  endtask

  task automatic make_data_words();
    for (int i = 0; i < num_cmds_c; i++)
    begin
      cmd_words[i] = '0;
      if (cmd_table[i].use_lcg)
      begin
        lcg_state          = lcg_step(lcg_state);
        cmd_words[i][63:32] = lcg_state;
        lcg_state          = lcg_step(lcg_state);
        cmd_words[i][31:0]  = lcg_state;
      end
    end
  endtask

  // drive one command, hold it until taken, then wait for its last beat
  task automatic run_cmd(input int idx);
    @(negedge clk);
    cmd_header.msg_type = cmd_table[idx].msg_type;
    cmd_header.addr     = cmd_table[idx].addr;
    cmd_header.size     = cmd_table[idx].size;
    cmd_data            = cmd_words[idx];
    stall_en            = cmd_table[idx].stall;
    exp_beats           = int'(cmd_table[idx].beats);
    cmd_v               = 1'b1;
    @(posedge clk);
    while (!cmd_ready_and)
      @(posedge clk);
    @(negedge clk);
    cmd_v = 1'b0;
    @(posedge clk);
    while (!(resp_v && resp_ready_and && resp_last))
      @(posedge clk);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // data words come first from the LCG, then it paces the back-pressure
  initial
  begin
    resp_ready_and = 1'b0;
    lcg_state      = 32'h5452c0cf;
    load_table();
    make_data_words();
    forever
    begin
      @(negedge clk);
      lcg_state      = lcg_step(lcg_state);
      resp_ready_and = stall_en ? lcg_state[16] : 1'b1;
    end
  end

  initial
  begin
    reset      = 1'b1;
    cmd_header = '0;
    cmd_data   = '0;
    cmd_v      = 1'b0;
    stall_en   = 1'b0;
    exp_beats  = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < num_cmds_c; i++)
      run_cmd(i);
    repeat (2) @(negedge clk);
    $display("commands %0d: %0d passed, %0d failed", num_cmds_c, pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (pass_cnt == num_cmds_c))
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > timeout_c)
    begin
      $display("timeout: the run did not finish within %0d cycles", timeout_c);
      $display("*** FAILED ***");
      $finish;
    end
  end

  stream_mem_top u_dut (
    .clk_i           (clk),
    .reset_i         (reset),
    .cmd_header_i    (cmd_header),
    .cmd_data_i      (cmd_data),
    .cmd_v_i         (cmd_v),
    .cmd_ready_and_o (cmd_ready_and),
    .resp_header_o   (resp_header),
    .resp_data_o     (resp_data),
    .resp_v_o        (resp_v),
    .resp_last_o     (resp_last),
    .resp_ready_and_i(resp_ready_and)
  );

  tb_resp_checker u_chk (
    .clk_i           (clk),
    .reset_i         (reset),
    .cmd_header_i    (cmd_header),
    .cmd_data_i      (cmd_data),
    .cmd_v_i         (cmd_v),
    .cmd_ready_and_i (cmd_ready_and),
    .exp_beats_i     (exp_beats),
    .resp_header_i   (resp_header),
    .resp_data_i     (resp_data),
    .resp_v_i        (resp_v),
    .resp_last_i     (resp_last),
    .resp_ready_and_i(resp_ready_and),
    .pass_cnt_o      (pass_cnt),
    .fail_cnt_o      (fail_cnt)
  );

endmodule

// File: stream_mem_top.f
bedrock_stream_pkg.sv
stream_wraparound.sv
stream_pump_out.sv
mem_resp_fsm.sv
stream_mem_top.sv
tb_resp_checker.sv
tb_stream_mem.sv

// File: Makefile
# Verilator build and run of the stream memory endpoint testbench

VERILATOR ?= verilator
TOP       ?= tb_stream_mem
FILELIST  ?= stream_mem_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
